// ==== source/bridge_defs.svh ====
// Width and depth macros for the AXI to AHB-Lite bridge
// Shared by the RTL and the testbench
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// Address bus, one word
`define ADDR_W 32

// AXI beat and AHB word
`define AXI_DATA_W 64
`define AHB_DATA_W 32

// Transaction ID and burst length field
`define ID_W  4
`define LEN_W 4

// Burst buffer, one entry per AXI beat
`define BUF_DEPTH 16
`define BUF_AW    4

`endif

// ==== source/axiPkg.sv ====
// AXI side types
// Response codes and the slave controller states
package axiPkg;

    // Only OKAY and SLVERR are ever returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axiRespT;

    // One transaction at a time, write or read
    typedef enum logic [2:0] {
        S_IDLE,
        S_WDATA,
        S_WAIT,
        S_BRESP,
        S_RDATA
    } slaveStateT;

endpackage

// ==== source/ahbPkg.sv ====
// AHB side types
// Transfer type, transfer size and the master controller states
package ahbPkg;

    // BUSY and SEQ never appear on the bus
    typedef enum logic [1:0] {
        H_IDLE   = 2'b00,
        H_BUSY   = 2'b01,
        H_NONSEQ = 2'b10,
        H_SEQ    = 2'b11
    } hTransT;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } hSizeT;

    typedef enum logic [1:0] {
        M_IDLE,
        M_XFER,
        M_LAST,
        M_ACK
    } masterStateT;

endpackage

// ==== source/burstRam.sv ====
// Burst buffer, one 64-bit entry per AXI beat
// Synchronous write, combinational read
`timescale 1ns/100ps
`include "bridge_defs.svh"

module burstRam (
    input  logic                   ACLK,
    input  logic                   wrEn,
    input  logic [`BUF_AW-1:0]     wrAddr,
    input  logic [`AXI_DATA_W-1:0] wrData,
    input  logic [`BUF_AW-1:0]     rdAddr,
    output logic [`AXI_DATA_W-1:0] rdData
);

    logic [`AXI_DATA_W-1:0] mem [`BUF_DEPTH];

    always_ff @(posedge ACLK)
    begin
        if (wrEn)
            mem[wrAddr] <= wrData;
    end

    // Zero latency read
    assign rdData = mem[rdAddr];

endmodule

// ==== source/axiSlaveCtrl.sv ====
// AXI slave controller
// Channel handshakes, write buffer fill, read buffer drain
// and the requesting side of the req/ack handshake
`timescale 1ns/100ps
`include "bridge_defs.svh"

module axiSlaveCtrl (
    input  logic                   ACLK,
    input  logic                   rstN,
    // Write address
    input  logic                   awValid,
    output logic                   awReady,
    input  logic [`ADDR_W-1:0]     awAddr,
    input  logic [`LEN_W-1:0]      awLen,
    input  logic [`ID_W-1:0]       awId,
    // Write data
    input  logic                   wValid,
    output logic                   wReady,
    input  logic [`AXI_DATA_W-1:0] wData,
    input  logic                   wLast,
    // Write response
    output logic                   bValid,
    input  logic                   bReady,
    output axiPkg::axiRespT        bResp,
    output logic [`ID_W-1:0]       bId,
    // Read address
    input  logic                   arValid,
    output logic                   arReady,
    input  logic [`ADDR_W-1:0]     arAddr,
    input  logic [`LEN_W-1:0]      arLen,
    input  logic [`ID_W-1:0]       arId,
    // Read data
    output logic                   rValid,
    input  logic                   rReady,
    output logic [`AXI_DATA_W-1:0] rData,
    output logic                   rLast,
    output axiPkg::axiRespT        rResp,
    output logic [`ID_W-1:0]       rId,
    // Request to the AHB master
    output logic                   tranReq,
    output logic                   tranWrite,
    output logic [`ADDR_W-1:0]     tranAddr,
    output logic [`LEN_W-1:0]      tranLen,
    input  logic                   tranAck,
    input  logic                   tranErr,
    // Write buffer fill
    output logic                   wrBufEn,
    output logic [`BUF_AW-1:0]     wrBufAddr,
    output logic [`AXI_DATA_W-1:0] wrBufData,
    // Read buffer drain
    output logic [`BUF_AW-1:0]     rdBufAddr,
    input  logic [`AXI_DATA_W-1:0] rdBufData
);

    import axiPkg::*;

    slaveStateT           state;
    logic [`LEN_W-1:0]    beatCnt;
    logic [`LEN_W-1:0]    lenQ;
    logic [`ID_W-1:0]     idQ;
    logic [`ADDR_W-1:0]   addrQ;
    logic                 writeQ;
    logic                 errQ;
    logic                 lastBeat;
    logic                 wAccept;
    logic                 rAccept;

    //////////////////////////////
    // Channel handshakes
    //////////////////////////////

    // Write wins when both address channels are valid
    assign awReady = (state == S_IDLE) && awValid && !tranAck;
    assign arReady = (state == S_IDLE) && arValid && !awValid && !tranAck;
    assign wReady  = (state == S_WDATA);
    assign bValid  = (state == S_BRESP);
    assign rValid  = (state == S_RDATA);

    assign wAccept  = wValid && wReady;
    assign rAccept  = rValid && rReady;
    // The beat count ends a burst, wLast only marks it
    assign lastBeat = (beatCnt == lenQ);

    //////////////////////////////
    // Controller FSM
    //////////////////////////////

    always_ff @(posedge ACLK or negedge rstN)
    begin
        if (!rstN)
        begin
            state   <= S_IDLE;
            beatCnt <= '0;
            writeQ  <= 1'b0;
            errQ    <= 1'b0;
            tranReq <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    beatCnt <= '0;
                    if (awReady)
                    begin
                        writeQ <= 1'b1;
                        state  <= S_WDATA;
                    end
                    else if (arReady)
                    begin
                        writeQ  <= 1'b0;
                        tranReq <= 1'b1;
                        state   <= S_WAIT;
                    end
                end
                S_WDATA:
                begin
                    if (wAccept)
                    begin
                        beatCnt <= beatCnt + 1'b1;
                        if (lastBeat)
                        begin
                            tranReq <= 1'b1;
                            state   <= S_WAIT;
                        end
                    end
                end
                S_WAIT:
                begin
                    // AHB side done, error flag is valid with the ack
                    if (tranAck)
                    begin
                        tranReq <= 1'b0;
                        errQ    <= tranErr;
                        beatCnt <= '0;
                        state   <= writeQ ? S_BRESP : S_RDATA;
                    end
                end
                S_BRESP:
                begin
                    if (bReady)
                        state <= S_IDLE;
                end
                S_RDATA:
                begin
                    if (rAccept)
                    begin
                        beatCnt <= beatCnt + 1'b1;
                        if (lastBeat)
                            state <= S_IDLE;
                    end
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // Address, length and ID of the accepted transaction
    always_ff @(posedge ACLK)
    begin
        if (awReady)
        begin
            idQ   <= awId;
            lenQ  <= awLen;
            addrQ <= {awAddr[`ADDR_W-1:3], 3'b000};
        end
        else if (arReady)
        begin
            idQ   <= arId;
            lenQ  <= arLen;
            addrQ <= {arAddr[`ADDR_W-1:3], 3'b000};
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign wrBufEn   = wAccept;
    assign wrBufAddr = beatCnt;
    assign wrBufData = wData;
    assign rdBufAddr = beatCnt;

    assign tranWrite = writeQ;
    assign tranAddr  = addrQ;
    assign tranLen   = lenQ;

    assign bResp = errQ ? RESP_SLVERR : RESP_OKAY;
    assign bId   = idQ;
    // Same response on every read beat
    assign rResp = errQ ? RESP_SLVERR : RESP_OKAY;
    assign rId   = idQ;
    assign rData = rdBufData;
    assign rLast = rValid && lastBeat;

endmodule

// ==== source/ahbMasterCtrl.sv ====
// AHB-Lite master controller
// Plays one buffered transaction out as single word transfers
`timescale 1ns/100ps
`include "bridge_defs.svh"

module ahbMasterCtrl (
    input  logic                   ACLK,
    input  logic                   rstN,
    // Request from the AXI side
    input  logic                   tranReq,
    input  logic                   tranWrite,
    input  logic [`ADDR_W-1:0]     tranAddr,
    input  logic [`LEN_W-1:0]      tranLen,
    output logic                   tranAck,
    output logic                   tranErr,
    // Write buffer read port
    output logic [`BUF_AW-1:0]     wrBufAddr,
    input  logic [`AXI_DATA_W-1:0] wrBufData,
    // Read buffer write port
    output logic                   rdBufEn,
    output logic [`BUF_AW-1:0]     rdBufAddr,
    output logic [`AXI_DATA_W-1:0] rdBufData,
    // AHB-Lite master
    output logic [`ADDR_W-1:0]     hAddr,
    output logic                   hWrite,
    output ahbPkg::hSizeT          hSize,
    output logic [2:0]             hBurst,
    output ahbPkg::hTransT         hTrans,
    output logic [`AHB_DATA_W-1:0] hWData,
    input  logic [`AHB_DATA_W-1:0] hRData,
    input  logic                   hReady,
    input  logic                   hResp
);

    import ahbPkg::*;

    masterStateT          state;
    // Word index, bit 0 picks the half of the beat
    logic [`LEN_W:0]      aCnt;
    logic [`LEN_W:0]      dCnt;
    logic [`LEN_W:0]      lastIdx;
    logic                 dPend;
    logic                 errQ;
    logic [`AHB_DATA_W-1:0] lowWordQ;

    assign lastIdx = {tranLen, 1'b1};

    //////////////////////////////
    // Address and data phases
    //////////////////////////////

    always_ff @(posedge ACLK or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= M_IDLE;
            aCnt  <= '0;
            dCnt  <= '0;
            dPend <= 1'b0;
            errQ  <= 1'b0;
        end
        else
        begin
            case (state)
                M_IDLE:
                begin
                    if (tranReq)
                    begin
                        aCnt  <= '0;
                        errQ  <= 1'b0;
                        state <= M_XFER;
                    end
                end
                M_XFER:
                begin
                    if (hReady)
                    begin
                        if (aCnt == lastIdx)
                            state <= M_LAST;
                        else
                            aCnt <= aCnt + 1'b1;
                    end
                end
                // Final data phase still on the bus
                M_LAST:
                begin
                    if (hReady)
                        state <= M_ACK;
                end
                M_ACK:
                begin
                    if (!tranReq)
                        state <= M_IDLE;
                end
                default:
                    state <= M_IDLE;
            endcase

            // Address phase hands over to the data phase on hReady
            if (hReady)
            begin
                dPend <= (state == M_XFER);
                dCnt  <= aCnt;
            end

            // Sticky until the next request, later transfers still run
            if (dPend && hResp)
                errQ <= 1'b1;
        end
    end

    // Low read word waits here for its high half
    always_ff @(posedge ACLK)
    begin
        if (dPend && hReady && !tranWrite && !dCnt[0])
            lowWordQ <= hRData;
    end

    //////////////////////////////
    // Bus and buffer outputs
    //////////////////////////////

    assign hTrans = (state == M_XFER) ? H_NONSEQ : H_IDLE;
    assign hAddr  = tranAddr + {{(`ADDR_W-`LEN_W-3){1'b0}}, aCnt, 2'b00};
    assign hWrite = tranWrite;
    assign hSize  = SIZE_WORD;
    // Always SINGLE
    assign hBurst = 3'b000;

    assign wrBufAddr = dCnt[`LEN_W:1];
    assign hWData    = dCnt[0] ? wrBufData[`AXI_DATA_W-1:`AHB_DATA_W]
                               : wrBufData[`AHB_DATA_W-1:0];

    assign rdBufEn   = dPend && hReady && !tranWrite && dCnt[0];
    assign rdBufAddr = dCnt[`LEN_W:1];
    assign rdBufData = {hRData, lowWordQ};

    assign tranAck = (state == M_ACK);
    assign tranErr = errQ;

endmodule

// ==== source/axiToAhbBridge.sv ====
// AXI to AHB-Lite bridge top level
// Slave and master controllers with the write and read burst buffers
`timescale 1ns/100ps
`include "bridge_defs.svh"

module axiToAhbBridge (
    input  logic                   ACLK,
    input  logic                   rstN,
    // AXI write address
    input  logic                   awValid,
    output logic                   awReady,
    input  logic [`ADDR_W-1:0]     awAddr,
    input  logic [`LEN_W-1:0]      awLen,
    input  logic [`ID_W-1:0]       awId,
    // AXI write data
    input  logic                   wValid,
    output logic                   wReady,
    input  logic [`AXI_DATA_W-1:0] wData,
    input  logic                   wLast,
    // AXI write response
    output logic                   bValid,
    input  logic                   bReady,
    output axiPkg::axiRespT        bResp,
    output logic [`ID_W-1:0]       bId,
    // AXI read address
    input  logic                   arValid,
    output logic                   arReady,
    input  logic [`ADDR_W-1:0]     arAddr,
    input  logic [`LEN_W-1:0]      arLen,
    input  logic [`ID_W-1:0]       arId,
    // AXI read data
    output logic                   rValid,
    input  logic                   rReady,
    output logic [`AXI_DATA_W-1:0] rData,
    output logic                   rLast,
    output axiPkg::axiRespT        rResp,
    output logic [`ID_W-1:0]       rId,
    // AHB-Lite master
    output logic [`ADDR_W-1:0]     hAddr,
    output logic                   hWrite,
    output ahbPkg::hSizeT          hSize,
    output logic [2:0]             hBurst,
    output ahbPkg::hTransT         hTrans,
    output logic [`AHB_DATA_W-1:0] hWData,
    input  logic [`AHB_DATA_W-1:0] hRData,
    input  logic                   hReady,
    input  logic                   hResp
);

    // Request handshake between the controllers
    logic                   tranReq;
    logic                   tranWrite;
    logic [`ADDR_W-1:0]     tranAddr;
    logic [`LEN_W-1:0]      tranLen;
    logic                   tranAck;
    logic                   tranErr;

    // Buffer ports
    logic                   wrBufEn;
    logic [`BUF_AW-1:0]     wrBufWrAddr;
    logic [`AXI_DATA_W-1:0] wrBufWrData;
    logic [`BUF_AW-1:0]     wrBufRdAddr;
    logic [`AXI_DATA_W-1:0] wrBufRdData;
    logic                   rdBufEn;
    logic [`BUF_AW-1:0]     rdBufWrAddr;
    logic [`AXI_DATA_W-1:0] rdBufWrData;
    logic [`BUF_AW-1:0]     rdBufRdAddr;
    logic [`AXI_DATA_W-1:0] rdBufRdData;

    axiSlaveCtrl i_axiSlaveCtrl (
        .*,
        .wrBufAddr (wrBufWrAddr),
        .wrBufData (wrBufWrData),
        .rdBufAddr (rdBufRdAddr),
        .rdBufData (rdBufRdData)
    );

    ahbMasterCtrl i_ahbMasterCtrl (
        .*,
        .wrBufAddr (wrBufRdAddr),
        .wrBufData (wrBufRdData),
        .rdBufAddr (rdBufWrAddr),
        .rdBufData (rdBufWrData)
    );

    // AXI side fills, AHB side drains
    burstRam wrBuf (
        .ACLK   (ACLK),
        .wrEn   (wrBufEn),
        .wrAddr (wrBufWrAddr),
        .wrData (wrBufWrData),
        .rdAddr (wrBufRdAddr),
        .rdData (wrBufRdData)
    );

    // AHB side fills, AXI side drains
    burstRam rdBuf (
        .ACLK   (ACLK),
        .wrEn   (rdBufEn),
        .wrAddr (rdBufWrAddr),
        .wrData (rdBufWrData),
        .rdAddr (rdBufRdAddr),
        .rdData (rdBufRdData)
    );

endmodule

// ==== verif/bridge_assertions.sv ====
// Protocol assertions for the AXI to AHB-Lite bridge
// AHB address hold, AXI valid hold and the req/ack handshake
`timescale 1ns/100ps
`include "bridge_defs.svh"

module bridge_assertions (
    input logic                ACLK,
    input logic                rstN,
    input ahbPkg::hTransT      hTrans,
    input logic [`ADDR_W-1:0]  hAddr,
    input logic                hWrite,
    input logic                hReady,
    input logic                bValid,
    input logic                bReady,
    input logic                rValid,
    input logic                rReady,
    input logic                tranReq,
    input logic                tranAck
);

    import ahbPkg::*;

    // Number of failed assertions
    int violations = 0;

    // Address phase is extended by wait states
    addrHold: assert property (@(posedge ACLK) disable iff (!rstN)
        (hTrans == H_NONSEQ && !hReady) |=> ($stable(hAddr) && $stable(hWrite)))
    else
    begin
        violations++;
        $error("hAddr or hWrite changed while hReady was low");
    end

    bValidHold: assert property (@(posedge ACLK) disable iff (!rstN)
        (bValid && !bReady) |=> bValid)
    else
    begin
        violations++;
        $error("bValid dropped before bReady");
    end

    rValidHold: assert property (@(posedge ACLK) disable iff (!rstN)
        (rValid && !rReady) |=> rValid)
    else
    begin
        violations++;
        $error("rValid dropped before rReady");
    end

    //////////////////////////////
    // Four-phase handshake
    //////////////////////////////

    reqHold: assert property (@(posedge ACLK) disable iff (!rstN)
        (tranReq && !tranAck) |=> tranReq)
    else
    begin
        violations++;
        $error("tranReq fell before tranAck rose");
    end

    ackNoReq: assert property (@(posedge ACLK) disable iff (!rstN)
        (!tranReq && !tranAck) |=> !tranAck)
    else
    begin
        violations++;
        $error("tranAck rose while tranReq was low");
    end

endmodule

bind axiToAhbBridge bridge_assertions chkProtocol (
    .ACLK    (ACLK),
    .rstN    (rstN),
    .hTrans  (hTrans),
    .hAddr   (hAddr),
    .hWrite  (hWrite),
    .hReady  (hReady),
    .bValid  (bValid),
    .bReady  (bReady),
    .rValid  (rValid),
    .rReady  (rReady),
    .tranReq (tranReq),
    .tranAck (tranAck)
);

// ==== verif/tbAxiToAhb.sv ====
// Testbench for the AXI to AHB-Lite bridge
// Clock, reset, AHB slave memory model, AXI driver tasks,
// directed tests and the final report
`timescale 1ns/100ps
`include "bridge_defs.svh"

module tbAxiToAhb;

    import axiPkg::*;
    import ahbPkg::*;

    // Error range of the AHB slave model
    localparam logic [31:0] errLo = 32'h0000_0800;
    localparam logic [31:0] errHi = 32'h0000_08FF;

    // Worst case per transaction is 32 transfers of up to 4 cycles
    // and 16 beats with up to 4 cycles of back-pressure, plus handshakes
    // Ten transactions with a margin of 8
    localparam int txnCycles    = 250;
    localparam int numTxns      = 10;
    localparam int marginFactor = 8;
    localparam int maxCycles    = txnCycles * numTxns * marginFactor;

    logic                   ACLK = 1'b0;
    logic                   rstN;
    logic                   awValid;
    logic                   awReady;
    logic [`ADDR_W-1:0]     awAddr;
    logic [`LEN_W-1:0]      awLen;
    logic [`ID_W-1:0]       awId;
    logic                   wValid;
    logic                   wReady;
    logic [`AXI_DATA_W-1:0] wData;
    logic                   wLast;
    logic                   bValid;
    logic                   bReady;
    axiRespT                bResp;
    logic [`ID_W-1:0]       bId;
    logic                   arValid;
    logic                   arReady;
    logic [`ADDR_W-1:0]     arAddr;
    logic [`LEN_W-1:0]      arLen;
    logic [`ID_W-1:0]       arId;
    logic                   rValid;
    logic                   rReady;
    logic [`AXI_DATA_W-1:0] rData;
    logic                   rLast;
    axiRespT                rResp;
    logic [`ID_W-1:0]       rId;
    logic [`ADDR_W-1:0]     hAddr;
    logic                   hWrite;
    hSizeT                  hSize;
    logic [2:0]             hBurst;
    hTransT                 hTrans;
    logic [`AHB_DATA_W-1:0] hWData;
    logic [`AHB_DATA_W-1:0] hRData;
    logic                   hReady;
    logic                   hResp;

    // Slave memory of 1024 words
    logic [31:0]            memWords [1024];

    // Beats to write and what came back
    logic [`AXI_DATA_W-1:0] wrBeats [16];
    logic [`AXI_DATA_W-1:0] rdBeats [16];
    logic                   rdLasts [16];
    axiRespT                rdResps [16];
    logic [`ID_W-1:0]       rdIds [16];
    axiRespT                bRespSeen;
    logic [`ID_W-1:0]       bIdSeen;

    logic [15:0]            waitLfsr = 16'd81;
    logic [15:0]            readyLfsr = 16'd81;
    int                     checkCnt = 0;
    int                     errCnt = 0;
    int                     cycleCnt = 0;

    axiToAhbBridge i_axiToAhbBridge (.*);

    always #4 ACLK = ~ACLK;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic logic [3:0] takeBits(inout logic [15:0] st, input int n);
        logic [3:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[2:0], st[0]};
            st = {1'b0, st[15:1]} ^ (st[0] ? 16'hB400 : 16'h0000);
        end
        return bits;
    endfunction

    // Initial memory contents depend on the full address
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic logic inErrRange(input logic [31:0] addr);
        return (addr >= errLo) && (addr <= errHi);
    endfunction

    function automatic logic [31:0] memAt(input logic [31:0] addr);
        return memWords[addr[11:2]];
    endfunction

    task automatic nextDrive();
        @(posedge ACLK);
        #1;
    endtask

    task automatic checkVal(input string name, input logic [63:0] expVal,
                            input logic [63:0] actVal);
        checkCnt++;
        assert (actVal === expVal)
        else
        begin
            errCnt++;
            $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expVal, actVal);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("Test %s done: %0d errors", name, errCnt - errBefore);
    endtask

    //////////////////////////////
    // AHB-Lite slave model
    //////////////////////////////

    initial
    begin : ahbSlave
        logic        dpActive;
        logic        dpWrite;
        logic        dpErr;
        logic [31:0] dpAddr;
        int          dpWait;
        for (int i = 0; i < 1024; i++)
            memWords[i] = fillWord(32'(i * 4));
        hReady   = 1'b1;
        hResp    = 1'b0;
        hRData   = '0;
        dpActive = 1'b0;
        dpWrite  = 1'b0;
        dpErr    = 1'b0;
        dpAddr   = '0;
        dpWait   = 0;
        forever
        begin
            @(posedge ACLK);
            // Data phase ends on hReady or spends one more wait state
            if (dpActive && hReady)
            begin
                if (dpWrite && !dpErr)
                    memWords[dpAddr[11:2]] = hWData;
                dpActive = 1'b0;
            end
            else if (dpActive)
                dpWait = dpWait - 1;
            if (hReady && hTrans == H_NONSEQ)
            begin
                // Word sized SINGLE transfers only
                checkVal("hSize", 64'(SIZE_WORD), 64'(hSize));
                checkVal("hBurst", 64'(3'b000), 64'(hBurst));
                dpActive = 1'b1;
                dpAddr   = hAddr;
                dpWrite  = hWrite;
                dpErr    = inErrRange(hAddr);
                dpWait   = int'(takeBits(waitLfsr, 2));
                if (dpWait == 3)
                    dpWait = 1;
                // ERROR needs its two-cycle response
                if (dpErr && dpWait == 0)
                    dpWait = 1;
            end
            #1;
            hReady = !dpActive || (dpWait == 0);
            hResp  = dpActive && dpErr && (dpWait <= 1);
            hRData = (dpActive && !dpWrite) ? memWords[dpAddr[11:2]] : '0;
        end
    end

    //////////////////////////////
    // AXI drivers
    //////////////////////////////

    task automatic axiWrite(input logic [31:0] addr, input logic [3:0] len,
                            input logic [3:0] id);
        int holdoff;
        awValid = 1'b1;
        awAddr  = addr;
        awLen   = len;
        awId    = id;
        @(negedge ACLK);
        while (!awReady)
            @(negedge ACLK);
        nextDrive();
        awValid = 1'b0;
        for (int i = 0; i <= int'(len); i++)
        begin
            wValid = 1'b1;
            wData  = wrBeats[i];
            wLast  = (i == int'(len));
            @(negedge ACLK);
            while (!wReady)
                @(negedge ACLK);
            nextDrive();
        end
        wValid = 1'b0;
        wLast  = 1'b0;
        @(negedge ACLK);
        while (!bValid)
            @(negedge ACLK);
        // bReady held back after bValid
        holdoff = int'(takeBits(readyLfsr, 2));
        nextDrive();
        repeat (holdoff)
            nextDrive();
        bReady = 1'b1;
        @(negedge ACLK);
        bRespSeen = bResp;
        bIdSeen   = bId;
        nextDrive();
        bReady = 1'b0;
    endtask

    task automatic axiRead(input logic [31:0] addr, input logic [3:0] len,
                           input logic [3:0] id);
        int holdoff;
        arValid = 1'b1;
        arAddr  = addr;
        arLen   = len;
        arId    = id;
        @(negedge ACLK);
        while (!arReady)
            @(negedge ACLK);
        nextDrive();
        arValid = 1'b0;
        for (int i = 0; i <= int'(len); i++)
        begin
            holdoff = int'(takeBits(readyLfsr, 2));
            rReady  = 1'b0;
            repeat (holdoff)
                nextDrive();
            rReady = 1'b1;
            @(negedge ACLK);
            while (!rValid)
                @(negedge ACLK);
            rdBeats[i] = rData;
            rdLasts[i] = rLast;
            rdResps[i] = rResp;
            rdIds[i]   = rId;
            nextDrive();
        end
        rReady = 1'b0;
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic testResetValues();
        int errBefore;
        errBefore = errCnt;
        @(negedge ACLK);
        checkVal("awReady", 64'(1'b0), 64'(awReady));
        checkVal("wReady", 64'(1'b0), 64'(wReady));
        checkVal("bValid", 64'(1'b0), 64'(bValid));
        checkVal("arReady", 64'(1'b0), 64'(arReady));
        checkVal("rValid", 64'(1'b0), 64'(rValid));
        checkVal("hTrans", 64'(H_IDLE), 64'(hTrans));
        nextDrive();
        reportTest("reset values", errBefore);
    endtask

    task automatic testSingleWrite();
        int errBefore;
        errBefore = errCnt;
        wrBeats[0] = 64'h1122_3344_5566_7788;
        axiWrite(32'h0000_0100, 4'd0, 4'd3);
        checkVal("bResp", 64'(RESP_OKAY), 64'(bRespSeen));
        checkVal("bId", 64'(4'd3), 64'(bIdSeen));
        // Low word at the address and high word 4 above
        checkVal("mem[0x100]", 64'(wrBeats[0][31:0]), 64'(memAt(32'h0000_0100)));
        checkVal("mem[0x104]", 64'(wrBeats[0][63:32]), 64'(memAt(32'h0000_0104)));
        reportTest("single write", errBefore);
    endtask

    task automatic testBurstWriteRead();
        int errBefore;
        errBefore = errCnt;
        for (int i = 0; i < 16; i++)
            wrBeats[i] = {8'hD0, 8'(i), 16'hBEEF, 8'hE0, 8'(i), 16'h1234};
        axiWrite(32'h0000_0200, 4'd15, 4'd5);
        checkVal("bResp", 64'(RESP_OKAY), 64'(bRespSeen));
        checkVal("bId", 64'(4'd5), 64'(bIdSeen));
        axiRead(32'h0000_0200, 4'd15, 4'd9);
        for (int i = 0; i < 16; i++)
        begin
            checkVal($sformatf("rData[%0d]", i), wrBeats[i], rdBeats[i]);
            checkVal($sformatf("rLast[%0d]", i), 64'(i == 15), 64'(rdLasts[i]));
            checkVal($sformatf("rResp[%0d]", i), 64'(RESP_OKAY), 64'(rdResps[i]));
            checkVal($sformatf("rId[%0d]", i), 64'(4'd9), 64'(rdIds[i]));
        end
        reportTest("burst write and read", errBefore);
    endtask

    task automatic testReadBackpressure();
        int          errBefore;
        logic [31:0] a;
        errBefore = errCnt;
        axiRead(32'h0000_0400, 4'd11, 4'd12);
        for (int i = 0; i < 12; i++)
        begin
            a = 32'h0000_0400 + 32'(8 * i);
            checkVal($sformatf("rData[%0d]", i), {fillWord(a + 32'd4), fillWord(a)},
                     rdBeats[i]);
            checkVal($sformatf("rLast[%0d]", i), 64'(i == 11), 64'(rdLasts[i]));
        end
        reportTest("read back-pressure", errBefore);
    endtask

    task automatic testErrorResponse();
        int errBefore;
        errBefore = errCnt;
        wrBeats[0] = 64'hDEAD_0001_DEAD_0000;
        wrBeats[1] = 64'hDEAD_0003_DEAD_0002;
        // First beat inside the error range and second beat outside
        axiWrite(32'h0000_08F8, 4'd1, 4'd2);
        checkVal("bResp", 64'(RESP_SLVERR), 64'(bRespSeen));
        checkVal("bId", 64'(4'd2), 64'(bIdSeen));
        axiRead(32'h0000_08F0, 4'd3, 4'd6);
        for (int i = 0; i < 4; i++)
            checkVal($sformatf("rResp[%0d]", i), 64'(RESP_SLVERR), 64'(rdResps[i]));
        // Error must not stick to later transactions
        wrBeats[0] = 64'h0BAD_F00D_CAFE_0042;
        axiWrite(32'h0000_0300, 4'd0, 4'd7);
        checkVal("bResp", 64'(RESP_OKAY), 64'(bRespSeen));
        axiRead(32'h0000_0300, 4'd0, 4'd8);
        checkVal("rResp[0]", 64'(RESP_OKAY), 64'(rdResps[0]));
        checkVal("rData[0]", wrBeats[0], rdBeats[0]);
        reportTest("error response", errBefore);
    endtask

    task automatic testWriteBeforeRead();
        int errBefore;
        errBefore = errCnt;
        for (int i = 0; i < 4; i++)
            wrBeats[i] = {8'h60, 8'(i), 16'h0DD0, 8'h70, 8'(i), 16'h0EE0};
        // Both address channels valid in the same cycle
        arValid = 1'b1;
        arAddr  = 32'h0000_0500;
        arLen   = 4'd3;
        arId    = 4'hB;
        axiWrite(32'h0000_0500, 4'd3, 4'hA);
        checkVal("bResp", 64'(RESP_OKAY), 64'(bRespSeen));
        checkVal("bId", 64'(4'hA), 64'(bIdSeen));
        axiRead(32'h0000_0500, 4'd3, 4'hB);
        for (int i = 0; i < 4; i++)
            checkVal($sformatf("rData[%0d]", i), wrBeats[i], rdBeats[i]);
        reportTest("write before read", errBefore);
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////

    always @(posedge ACLK)
    begin
        cycleCnt++;
        if (cycleCnt >= maxCycles)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", maxCycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial
    begin
        rstN    = 1'b0;
        awValid = 1'b0;
        awAddr  = '0;
        awLen   = '0;
        awId    = '0;
        wValid  = 1'b0;
        wData   = '0;
        wLast   = 1'b0;
        bReady  = 1'b0;
        arValid = 1'b0;
        arAddr  = '0;
        arLen   = '0;
        arId    = '0;
        rReady  = 1'b0;
        repeat (3)
            @(posedge ACLK);
        #1;
        rstN = 1'b1;

        testResetValues();
        testSingleWrite();
        testBurstWriteRead();
        testReadBackpressure();
        testErrorResponse();
        testWriteBeforeRead();

        $display("Summary: %0d checks, %0d value errors, %0d assertion failures",
                 checkCnt, errCnt, i_axiToAhbBridge.chkProtocol.violations);
        if (errCnt == 0 && i_axiToAhbBridge.chkProtocol.violations == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+source
source/axiPkg.sv
source/ahbPkg.sv
source/burstRam.sv
source/axiSlaveCtrl.sv
source/ahbMasterCtrl.sv
source/axiToAhbBridge.sv
verif/bridge_assertions.sv
verif/tbAxiToAhb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tbAxiToAhb -f all.f -o simv

out=$(./obj_dir/simv +verilator+error+limit+100)
echo "$out"

if echo "$out" | grep -qxF '*** PASSED ***'
then
    exit 0
fi
exit 1
